/* logic/lrelu_pkg.sv */
package lrelu_pkg;

  function automatic int CEIL(input int a, input int b);
    return (a + b - 1) / b;
  endfunction

  // B beats for one (clr_i, mtb) pair
  function automatic int calc_beats_b(input int clr_i, input int kw2, input int members);
    int clr_kw;
    int kw;
    int width_b;
    int write_depth;
    clr_kw      = clr_i * 2 + 1;
    kw          = kw2 * 2 + 1;
    width_b     = members / clr_kw;
    write_depth = 2 * (members / kw);
    return CEIL(write_depth, width_b);
  endfunction

  function automatic int calc_beats_max(input int kernel_w_max, input int members);
    int result;
    result = 2; // A beats at kw = 1
    for (int kw2 = 0; kw2 <= kernel_w_max / 2; kw2++) begin
      for (int clr = 0; clr <= kw2; clr++) begin
        if (calc_beats_b(clr, kw2, members) > result) result = calc_beats_b(clr, kw2, members);
      end
    end
    return result;
  endfunction

  // D beat + A beats + all B beats
  function automatic int calc_beats_total(input int kw2, input int members);
    int total;
    total = 1 + CEIL(2, kw2 * 2 + 1);
    for (int clr = 0; clr <= kw2; clr++) begin
      for (int mtb = 0; mtb <= clr * 2; mtb++) total += calc_beats_b(clr, kw2, members);
    end
    return total;
  endfunction

  function automatic int calc_beats_total_max(input int kernel_w_max, input int members);
    int result;
    result = 0;
    for (int kw2 = 0; kw2 <= kernel_w_max / 2; kw2++) begin
      if (calc_beats_total(kw2, members) > result) result = calc_beats_total(kw2, members);
    end
    return result;
  endfunction

  localparam int MEMBERS_DEF      = 12;
  localparam int KERNEL_W_MAX_DEF = 5;
  localparam int DATA_W_DEF       = 16;
  // D word lives in a register, not in RAM
  localparam int RAM_DEPTH_DEF =
    1 << $clog2(calc_beats_total_max(KERNEL_W_MAX_DEF, MEMBERS_DEF) - 1);

  localparam int KW_1_W     = $clog2(KERNEL_W_MAX_DEF);
  localparam int CLR_I_W    = $clog2(KERNEL_W_MAX_DEF / 2 + 1);
  localparam int MTB_W      = $clog2(KERNEL_W_MAX_DEF);
  localparam int W_ADDR_W   = $clog2(calc_beats_max(KERNEL_W_MAX_DEF, MEMBERS_DEF) + 1);
  localparam int RAM_ADDR_W = $clog2(RAM_DEPTH_DEF);

  typedef enum logic [1:0] {
    DEST_REG_D  = 2'd1,
    DEST_BRAM_A = 2'd2,
    DEST_BRAM_B = 2'd3
  } dest_e;

  typedef struct packed {
    dest_e                 dest;
    logic [CLR_I_W-1:0]    clr_i;
    logic [MTB_W-1:0]      mtb;
    logic [W_ADDR_W-1:0]   w_addr;
    logic [RAM_ADDR_W-1:0] ram_addr;
  } beat_t;

  typedef struct packed {
    logic                  we;
    logic [RAM_ADDR_W-1:0] addr;
    logic [DATA_W_DEF-1:0] wdata;
  } ram_req_t;

  localparam int ADDR_W = 10;

  localparam logic [ADDR_W-1:0] ADR_CTRL     = 10'd0;
  localparam logic [ADDR_W-1:0] ADR_DATA     = 10'd1;
  localparam logic [ADDR_W-1:0] ADR_STATUS   = 10'd2; // done at bit 0, beat count from bit 8
  localparam logic [ADDR_W-1:0] ADR_DREG     = 10'd3;
  localparam logic [ADDR_W-1:0] ADR_RAM_BASE = 10'd256;

endpackage

/* logic/lrelu_beats_counter.sv */
`timescale 1ns/1ps

module lrelu_beats_counter #(
  parameter int MEMBERS      = lrelu_pkg::MEMBERS_DEF,
  parameter int KERNEL_W_MAX = lrelu_pkg::KERNEL_W_MAX_DEF
) (
  input  logic                        clk,
  input  logic                        reset_i,
  input  logic                        beat_en_i,
  input  logic                        clear_i,
  input  logic [lrelu_pkg::KW_1_W-1:0] kw_1_i,
  output lrelu_pkg::beat_t            beat_o,
  output logic                        full_o
);

  import lrelu_pkg::*;

  localparam int KW2_MAX = KERNEL_W_MAX / 2;

  dest_e                 dest;
  logic [CLR_I_W-1:0]    clr_i;
  logic [MTB_W-1:0]      mtb;
  logic [W_ADDR_W-1:0]   w_addr;
  logic [RAM_ADDR_W-1:0] ram_addr;

  logic [CLR_I_W-1:0] kw2;
  logic               clr_last;
  logic               mtb_last;
  logic               a_last;
  logic               b_last;

  // Last w_addr per kernel width, and per clr_i for B
  logic [W_ADDR_W-1:0] a_last_lut [KW2_MAX+1];
  logic [W_ADDR_W-1:0] b_last_lut [KW2_MAX+1][KW2_MAX+1];

  for (genvar g_kw2 = 0; g_kw2 <= KW2_MAX; g_kw2++) begin : g_lut_kw
    assign a_last_lut[g_kw2] = W_ADDR_W'(CEIL(2, g_kw2 * 2 + 1) - 1);
    for (genvar g_clr = 0; g_clr <= KW2_MAX; g_clr++) begin : g_lut_clr
      if (g_clr <= g_kw2) begin : g_used
        assign b_last_lut[g_kw2][g_clr] = W_ADDR_W'(calc_beats_b(g_clr, g_kw2, MEMBERS) - 1);
      end else begin : g_unused
        assign b_last_lut[g_kw2][g_clr] = '0;
      end
    end
  end

  assign kw2      = CLR_I_W'(kw_1_i >> 1);
  assign clr_last = clr_i == kw2;
  assign mtb_last = mtb == MTB_W'({clr_i, 1'b0}); // mtb runs to 2*clr_i
  assign a_last   = w_addr == a_last_lut[kw2];
  assign b_last   = w_addr == b_last_lut[kw2][clr_i];

  assign full_o = (dest == DEST_BRAM_B) && b_last && mtb_last && clr_last;

  always_ff @(posedge clk) begin
    if (reset_i || clear_i) begin
      dest     <= DEST_REG_D;
      clr_i    <= '0;
      mtb      <= '0;
      w_addr   <= '0;
      ram_addr <= '0;
    end else if (beat_en_i) begin
      case (dest)
        DEST_REG_D: begin
          dest <= DEST_BRAM_A;
        end
        DEST_BRAM_A: begin
          ram_addr <= ram_addr + 1'b1;
          if (a_last) begin
            w_addr <= '0;
            dest   <= DEST_BRAM_B;
          end else begin
            w_addr <= w_addr + 1'b1;
          end
        end
        DEST_BRAM_B: begin
          ram_addr <= ram_addr + 1'b1;
          if (!b_last) begin
            w_addr <= w_addr + 1'b1;
          end else begin
            w_addr <= '0;
            if (!mtb_last) begin
              mtb <= mtb + 1'b1;
            end else begin
              mtb <= '0;
              if (!clr_last) begin
                clr_i <= clr_i + 1'b1;
              end else begin
                // Sequence complete, back to the D beat
                clr_i    <= '0;
                ram_addr <= '0;
                dest     <= DEST_REG_D;
              end
            end
          end
        end
        default: dest <= DEST_REG_D;
      endcase
    end
  end

  assign beat_o.dest     = dest;
  assign beat_o.clr_i    = clr_i;
  assign beat_o.mtb      = mtb;
  assign beat_o.w_addr   = w_addr;
  assign beat_o.ram_addr = ram_addr;

endmodule

/* logic/lrelu_param_ram.sv */
`timescale 1ns/1ps

module lrelu_param_ram #(
  parameter int DATA_W    = lrelu_pkg::DATA_W_DEF,
  parameter int RAM_DEPTH = lrelu_pkg::RAM_DEPTH_DEF
) (
  input  logic                clk,
  input  lrelu_pkg::ram_req_t req_i,
  input  logic                en_i,
  output logic [DATA_W-1:0]   rdata_o
);

  import lrelu_pkg::*;

  logic [DATA_W-1:0] mem [RAM_DEPTH];

  // Write has priority, read data shows up next cycle
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (req_i.we) begin
        mem[req_i.addr] <= req_i.wdata;
      end else begin
        rdata_o <= mem[req_i.addr];
      end
    end
  end

endmodule

/* logic/lrelu_ram_arbiter.sv */
`timescale 1ns/1ps

module lrelu_ram_arbiter #(
  parameter int RAM_DEPTH = lrelu_pkg::RAM_DEPTH_DEF
) (
  input  logic                         clk,
  input  logic                         reset_i,
  input  logic                         wr_req_i,
  input  lrelu_pkg::ram_req_t          wr_i,
  output logic                         wr_gnt_o,
  input  logic                         rd_req_i,
  input  logic [$clog2(RAM_DEPTH)-1:0] rd_addr_i,
  output logic                         rd_gnt_o,
  output logic                         rd_valid_o,
  input  logic                         lut_req_i,
  input  logic [$clog2(RAM_DEPTH)-1:0] lut_addr_i,
  output logic                         lut_valid_o,
  output lrelu_pkg::ram_req_t          ram_req_o,
  output logic                         ram_en_o
);

  import lrelu_pkg::*;

  logic lut_gnt;
  logic lut_served;
  logic rd_served;

  // Fixed priority: posted write, datapath, host
  assign wr_gnt_o = wr_req_i;
  assign lut_gnt  = lut_req_i && !lut_served && !wr_req_i;
  assign rd_gnt_o = rd_req_i && !rd_served && !wr_req_i && !lut_gnt;
  assign ram_en_o = wr_gnt_o || lut_gnt || rd_gnt_o;

  always_comb begin
    ram_req_o = '0;
    if (wr_gnt_o) begin
      ram_req_o = wr_i;
    end else if (lut_gnt) begin
      ram_req_o.addr = lut_addr_i;
    end else if (rd_gnt_o) begin
      ram_req_o.addr = rd_addr_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      lut_valid_o <= 1'b0;
      rd_valid_o  <= 1'b0;
      lut_served  <= 1'b0;
      rd_served   <= 1'b0;
    end else begin
      lut_valid_o <= lut_gnt; // RAM data is out one cycle after grant
      rd_valid_o  <= rd_gnt_o;
      // Held requests stay masked until dropped for a cycle
      if (lut_gnt) begin
        lut_served <= 1'b1;
      end else if (!lut_req_i) begin
        lut_served <= 1'b0;
      end
      if (rd_gnt_o) begin
        rd_served <= 1'b1;
      end else if (!rd_req_i) begin
        rd_served <= 1'b0;
      end
    end
  end

endmodule

/* logic/lrelu_wb_slave.sv */
`timescale 1ns/1ps

module lrelu_wb_slave #(
  parameter int DATA_W    = lrelu_pkg::DATA_W_DEF,
  parameter int RAM_DEPTH = lrelu_pkg::RAM_DEPTH_DEF
) (
  input  logic                         clk,
  input  logic                         reset_i,
  input  logic                         wb_cyc_i,
  input  logic                         wb_stb_i,
  input  logic                         wb_we_i,
  input  logic [lrelu_pkg::ADDR_W-1:0] wb_adr_i,
  input  logic [DATA_W-1:0]            wb_dat_i,
  output logic [DATA_W-1:0]            wb_dat_o,
  output logic                         wb_ack_o,
  input  lrelu_pkg::beat_t             beat_i,
  input  logic                         full_i,
  output logic                         beat_en_o,
  output logic                         clear_o,
  output logic [lrelu_pkg::KW_1_W-1:0] kw_1_o,
  output logic                         wr_req_o,
  output lrelu_pkg::ram_req_t          wr_o,
  input  logic                         wr_gnt_i,
  output logic                         rd_req_o,
  output logic [$clog2(RAM_DEPTH)-1:0] rd_addr_o,
  input  logic                         rd_valid_i,
  input  logic [DATA_W-1:0]            ram_rdata_i
);

  import lrelu_pkg::*;

  localparam int RA_W  = $clog2(RAM_DEPTH);
  localparam int CNT_W = RA_W + 1;

  logic              cyc_stb;
  logic              is_data;
  logic              is_ram;
  logic [ADDR_W-1:0] ram_off;
  logic              data_blocked;
  logic              acc;
  logic [DATA_W-1:0] d_reg;
  logic              done;
  logic [CNT_W-1:0]  beat_cnt;
  logic [DATA_W-1:0] status_word;

  assign cyc_stb = wb_cyc_i && wb_stb_i;
  assign is_data = wb_adr_i == ADR_DATA;
  assign ram_off = wb_adr_i - ADR_RAM_BASE;
  assign is_ram  = (wb_adr_i >= ADR_RAM_BASE) && (ram_off < RAM_DEPTH);

  // Buffer still full and not draining this cycle
  assign data_blocked = wb_we_i && is_data && !done && beat_i.dest != DEST_REG_D &&
                        wr_req_o && !wr_gnt_i;

  // Everything except host RAM reads acks one cycle later
  assign acc = cyc_stb && !wb_ack_o && !(is_ram && !wb_we_i) && !data_blocked;

  assign beat_en_o = acc && wb_we_i && is_data && !done;
  assign clear_o   = acc && wb_we_i && (wb_adr_i == ADR_CTRL);

  always_comb begin
    status_word              = '0;
    status_word[0]           = done;
    status_word[8 +: CNT_W]  = beat_cnt;
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wb_ack_o <= 1'b0;
      kw_1_o   <= '0;
      d_reg    <= '0;
      done     <= 1'b0;
      beat_cnt <= '0;
      wr_req_o <= 1'b0;
      rd_req_o <= 1'b0;
    end else begin
      wb_ack_o <= acc || rd_valid_i;
      if (clear_o) begin
        kw_1_o   <= wb_dat_i[KW_1_W-1:0];
        done     <= 1'b0;
        beat_cnt <= '0;
      end
      if (beat_en_o) begin
        beat_cnt <= beat_cnt + 1'b1;
        if (full_i) done <= 1'b1;
        if (beat_i.dest == DEST_REG_D) d_reg <= wb_dat_i;
      end
      if (beat_en_o && beat_i.dest != DEST_REG_D) begin
        wr_req_o <= 1'b1;
      end else if (wr_gnt_i) begin
        wr_req_o <= 1'b0;
      end
      // Host RAM read waits on the arbiter
      if (rd_valid_i) begin
        rd_req_o <= 1'b0;
      end else if (cyc_stb && !wb_ack_o && is_ram && !wb_we_i && !rd_req_o) begin
        rd_req_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beat_en_o && beat_i.dest != DEST_REG_D) begin
      wr_o.we    <= 1'b1;
      wr_o.addr  <= beat_i.ram_addr;
      wr_o.wdata <= wb_dat_i;
    end
    if (cyc_stb && !rd_req_o) rd_addr_o <= ram_off[RA_W-1:0];
    if (rd_valid_i) begin
      wb_dat_o <= ram_rdata_i;
    end else if (acc && !wb_we_i) begin
      case (wb_adr_i)
        ADR_CTRL:   wb_dat_o <= DATA_W'(kw_1_o);
        ADR_STATUS: wb_dat_o <= status_word;
        ADR_DREG:   wb_dat_o <= d_reg;
        default:    wb_dat_o <= '0;
      endcase
    end
  end

endmodule

/* logic/lrelu_loader_top.sv */
`timescale 1ns/1ps

module lrelu_loader_top #(
  parameter int MEMBERS      = lrelu_pkg::MEMBERS_DEF,
  parameter int KERNEL_W_MAX = lrelu_pkg::KERNEL_W_MAX_DEF,
  parameter int DATA_W       = lrelu_pkg::DATA_W_DEF,
  parameter int RAM_DEPTH    = lrelu_pkg::RAM_DEPTH_DEF
) (
  input  logic                         clk,
  input  logic                         reset_i,
  input  logic                         wb_cyc_i,
  input  logic                         wb_stb_i,
  input  logic                         wb_we_i,
  input  logic [lrelu_pkg::ADDR_W-1:0] wb_adr_i,
  input  logic [DATA_W-1:0]            wb_dat_i,
  output logic [DATA_W-1:0]            wb_dat_o,
  output logic                         wb_ack_o,
  input  logic                         lut_req_i,
  input  logic [$clog2(RAM_DEPTH)-1:0] lut_addr_i,
  output logic [DATA_W-1:0]            lut_data_o,
  output logic                         lut_valid_o
);

  import lrelu_pkg::*;

  beat_t                        beat;
  logic                         full;
  logic                         beat_en;
  logic                         clear;
  logic [KW_1_W-1:0]            kw_1;
  logic                         wr_req;
  ram_req_t                     wr;
  logic                         wr_gnt;
  logic                         rd_req;
  logic [$clog2(RAM_DEPTH)-1:0] rd_addr;
  logic                         rd_valid;
  ram_req_t                     ram_req;
  logic                         ram_en;

  lrelu_wb_slave #(.DATA_W(DATA_W), .RAM_DEPTH(RAM_DEPTH)) i_lrelu_wb_slave (
    .clk, .reset_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
    .beat_i(beat), .full_i(full), .beat_en_o(beat_en), .clear_o(clear), .kw_1_o(kw_1),
    .wr_req_o(wr_req), .wr_o(wr), .wr_gnt_i(wr_gnt), .rd_req_o(rd_req), .rd_addr_o(rd_addr),
    .rd_valid_i(rd_valid), .ram_rdata_i(lut_data_o)
  );

  lrelu_beats_counter #(.MEMBERS(MEMBERS), .KERNEL_W_MAX(KERNEL_W_MAX)) i_lrelu_beats_counter (
    .clk, .reset_i, .beat_en_i(beat_en), .clear_i(clear), .kw_1_i(kw_1),
    .beat_o(beat), .full_o(full)
  );

  lrelu_ram_arbiter #(.RAM_DEPTH(RAM_DEPTH)) i_lrelu_ram_arbiter (
    .clk, .reset_i, .wr_req_i(wr_req), .wr_i(wr), .wr_gnt_o(wr_gnt),
    .rd_req_i(rd_req), .rd_addr_i(rd_addr), .rd_gnt_o(), .rd_valid_o(rd_valid),
    .lut_req_i, .lut_addr_i, .lut_valid_o, .ram_req_o(ram_req), .ram_en_o(ram_en)
  );

  // Datapath and host share the RAM output
  lrelu_param_ram #(.DATA_W(DATA_W), .RAM_DEPTH(RAM_DEPTH)) i_lrelu_param_ram (
    .clk, .req_i(ram_req), .en_i(ram_en), .rdata_o(lut_data_o)
  );

endmodule

/* verif/lrelu_loader_props.sv */
`timescale 1ns/1ps

module lrelu_loader_props #(
  parameter int MEMBERS      = lrelu_pkg::MEMBERS_DEF,
  parameter int KERNEL_W_MAX = lrelu_pkg::KERNEL_W_MAX_DEF
) (
  input logic             clk,
  input logic             reset_i,
  input logic             beat_en_i,
  input logic             clear_i,
  input lrelu_pkg::beat_t beat_o,
  input logic             full_o
);

  import lrelu_pkg::*;

  localparam int BEATS_MAX = calc_beats_max(KERNEL_W_MAX, MEMBERS);

  int fail_cnt = 0; // Read by the testbench at the end

  a_dest_legal: assert property (@(posedge clk) disable iff (reset_i)
    beat_o.dest != 2'b00)
    else begin
      $error("beats counter dest is zero");
      fail_cnt++;
    end

  a_full_in_b: assert property (@(posedge clk) disable iff (reset_i)
    full_o |-> beat_o.dest == DEST_BRAM_B)
    else begin
      $error("full_o outside the B beats");
      fail_cnt++;
    end

  a_w_addr_range: assert property (@(posedge clk) disable iff (reset_i)
    int'(beat_o.w_addr) < BEATS_MAX)
    else begin
      $error("w_addr beyond the largest beat count");
      fail_cnt++;
    end

  // Only A and B beats move the RAM address
  a_ram_addr_hold: assert property (@(posedge clk) disable iff (reset_i)
    !clear_i && !(beat_en_i && beat_o.dest != DEST_REG_D) |=> $stable(beat_o.ram_addr))
    else begin
      $error("ram_addr changed without an A or B beat");
      fail_cnt++;
    end

endmodule

bind lrelu_beats_counter lrelu_loader_props #(
  .MEMBERS(MEMBERS),
  .KERNEL_W_MAX(KERNEL_W_MAX)
) i_lrelu_loader_props (
  .clk, .reset_i, .beat_en_i, .clear_i, .beat_o, .full_o
);

/* verif/lrelu_loader_tb.sv */
`timescale 1ns/1ps

module lrelu_loader_tb;

  import lrelu_pkg::*;

  localparam int RA_W           = $clog2(RAM_DEPTH_DEF);
  localparam int TIMEOUT_CYCLES = 4000;

  logic              clk = 1'b0;
  logic              reset_i;
  logic              wb_cyc_i;
  logic              wb_stb_i;
  logic              wb_we_i;
  logic [ADDR_W-1:0] wb_adr_i;
  logic [15:0]       wb_dat_i;
  logic [15:0]       wb_dat_o;
  logic              wb_ack_o;
  logic              lut_req_i;
  logic [RA_W-1:0]   lut_addr_i;
  logic [15:0]       lut_data_o;
  logic              lut_valid_o;

  logic [15:0] lfsr_state = 16'd86;
  int          err_cnt    = 0;
  int          cycle_cnt  = 0;
  int          props_fail;
  logic [15:0] model_d;
  logic [15:0] model_ram [RAM_DEPTH_DEF];
  logic [15:0] old_ram [RAM_DEPTH_DEF];
  logic [15:0] load_words [RAM_DEPTH_DEF + 1];

  always #5 clk = ~clk;

  lrelu_loader_top i_lrelu_loader_top (.*);

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // Galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? (s >> 1) ^ 16'hB400 : s >> 1;
  endfunction

  // Done flag at bit 0, beat count from bit 8
  function automatic logic [15:0] expected_status(input bit done, input int count);
    return (16'(count) << 8) | 16'(done);
  endfunction

  task automatic report_mismatch(input string what, input logic [15:0] got,
                                 input logic [15:0] exp);
    $display("CHECK FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
    err_cnt++;
  endtask

  task automatic draw_words(input int n);
    for (int i = 0; i < n; i++) begin
      load_words[i] = '0;
      for (int b = 0; b < 16; b++) begin
        lfsr_state    = lfsr_next(lfsr_state);
        load_words[i] = {load_words[i][14:0], lfsr_state[0]};
      end
    end
  endtask

  task automatic wb_access(input logic we, input logic [ADDR_W-1:0] adr,
                           input logic [15:0] wdata, output logic [15:0] rdata);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdata;
    @(negedge clk);
    while (!wb_ack_o) @(negedge clk);
    rdata    = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input logic [ADDR_W-1:0] adr, input logic [15:0] data);
    logic [15:0] ignored;
    wb_access(1'b1, adr, data, ignored);
  endtask

  task automatic wb_read(input logic [ADDR_W-1:0] adr, output logic [15:0] data);
    wb_access(1'b0, adr, 16'h0, data);
  endtask

  task automatic lut_read(input int addr, output logic [15:0] data);
    lut_req_i  = 1'b1;
    lut_addr_i = RA_W'(addr);
    @(negedge clk);
    while (!lut_valid_o) @(negedge clk);
    data      = lut_data_o;
    lut_req_i = 1'b0;
    @(negedge clk); // Request low for a cycle so it can be served again
  endtask

  task automatic push_words(input int n, input bit track_status);
    logic [15:0] rdata;
    for (int i = 0; i < n; i++) begin
      wb_write(ADR_DATA, load_words[i]);
      if (track_status) begin
        wb_read(ADR_STATUS, rdata);
        if (rdata !== expected_status(i == n - 1, i + 1)) begin
          report_mismatch("STATUS during load", rdata, expected_status(i == n - 1, i + 1));
        end
      end
    end
  endtask

  // Beat 0 is the D word, beat n lands at RAM n-1
  task automatic commit_model(input int n);
    model_d = load_words[0];
    for (int i = 1; i < n; i++) model_ram[i-1] = load_words[i];
  endtask

  task automatic host_sweep(input int words);
    logic [15:0] rdata;
    for (int a = 0; a < words; a++) begin
      wb_read(ADR_RAM_BASE + ADDR_W'(a), rdata);
      if (rdata !== model_ram[a]) report_mismatch($sformatf("RAM[%0d]", a), rdata, model_ram[a]);
    end
  endtask

  task automatic lut_sweep(input int words);
    logic [15:0] rdata;
    for (int a = words - 1; a >= 0; a--) begin
      lut_read(a, rdata);
      if (rdata !== model_ram[a]) report_mismatch($sformatf("LUT[%0d]", a), rdata, model_ram[a]);
    end
  endtask

  // Each lookup sees the word from before or after the reload
  task automatic lut_stream(input int count, input int words);
    logic [15:0] rdata;
    int          a;
    for (int i = 0; i < count; i++) begin
      a = i % words;
      lut_read(a, rdata);
      if (rdata !== old_ram[a] && rdata !== load_words[a + 1]) begin
        report_mismatch($sformatf("LUT[%0d] during load", a), rdata, load_words[a + 1]);
      end
    end
  endtask

  task automatic verify_contents(input int n);
    logic [15:0] rdata;
    wb_read(ADR_DREG, rdata);
    if (rdata !== model_d) report_mismatch("DREG", rdata, model_d);
    host_sweep(n - 1);
  endtask

  task automatic test_reset_state();
    logic [15:0] rdata;
    wb_read(ADR_STATUS, rdata);
    if (rdata !== expected_status(1'b0, 0)) report_mismatch("STATUS after reset", rdata, 16'h0);
    wb_read(ADR_DREG, rdata);
    if (rdata !== 16'h0) report_mismatch("DREG after reset", rdata, 16'h0);
  endtask

  task automatic test_kw1_load();
    int n;
    n = calc_beats_total(0, MEMBERS_DEF);
    draw_words(n);
    wb_write(ADR_CTRL, 16'd0); // kw_1 = 0
    push_words(n, 1'b1);
    commit_model(n);
    verify_contents(n);
  endtask

  task automatic test_kw5_reload();
    int          n;
    logic [15:0] rdata;
    n = calc_beats_total(2, MEMBERS_DEF);
    wb_write(ADR_CTRL, 16'd4);
    wb_read(ADR_STATUS, rdata);
    if (rdata !== expected_status(1'b0, 0)) report_mismatch("STATUS after CTRL", rdata, 16'h0);
    draw_words(n);
    push_words(n, 1'b1);
    commit_model(n);
    draw_words(3); // Dropped, done is already set
    push_words(3, 1'b0);
    wb_read(ADR_STATUS, rdata);
    if (rdata !== expected_status(1'b1, n)) begin
      report_mismatch("STATUS after extra words", rdata, expected_status(1'b1, n));
    end
    verify_contents(n);
  endtask

  task automatic test_back_pressure();
    int n;
    n       = calc_beats_total(2, MEMBERS_DEF);
    old_ram = model_ram;
    draw_words(n);
    wb_write(ADR_CTRL, 16'd4);
    fork
      push_words(n, 1'b0);
      lut_stream(40, n - 1);
    join
    commit_model(n);
    verify_contents(n);
  endtask

  task automatic test_shared_reads();
    fork
      host_sweep(calc_beats_total(2, MEMBERS_DEF) - 1);
      lut_sweep(calc_beats_total(2, MEMBERS_DEF) - 1);
    join
  endtask

  initial begin
    reset_i    = 1'b1;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_adr_i   = '0;
    wb_dat_i   = '0;
    lut_req_i  = 1'b0;
    lut_addr_i = '0;
    repeat (8) @(negedge clk);
    reset_i = 1'b0;
    @(negedge clk);
    test_reset_state();
    test_kw1_load();
    test_kw5_reload();
    test_back_pressure();
    test_shared_reads();
    props_fail = i_lrelu_loader_top.i_lrelu_beats_counter.i_lrelu_loader_props.fail_cnt;
    $display("Errors: %0d check, %0d assertion", err_cnt, props_fail);
    if (err_cnt == 0 && props_fail == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* sim.f */
logic/lrelu_pkg.sv
logic/lrelu_beats_counter.sv
logic/lrelu_param_ram.sv
logic/lrelu_ram_arbiter.sv
logic/lrelu_wb_slave.sv
logic/lrelu_loader_top.sv
verif/lrelu_loader_props.sv
verif/lrelu_loader_tb.sv

/* Bender.yml */
package:
  name: lrelu_loader

sources:
  - files:
      - logic/lrelu_pkg.sv
      - logic/lrelu_beats_counter.sv
      - logic/lrelu_param_ram.sv
      - logic/lrelu_ram_arbiter.sv
      - logic/lrelu_wb_slave.sv
      - logic/lrelu_loader_top.sv
  - target: test
    files:
      - verif/lrelu_loader_props.sv
      - verif/lrelu_loader_tb.sv
